// ==== hdl/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    // funct3 for ALU ops
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_slt = 3'b010;
    localparam logic [2:0] f3_xor = 3'b100;
    localparam logic [2:0] f3_or  = 3'b110;
    localparam logic [2:0] f3_and = 3'b111;

    // BEQ is 000, only BNE needs telling apart
    localparam logic [2:0] f3_bne = 3'b001;

    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_ex,
        fwd_mem
    } fwd_sel_t;

    // ADDI x0, x0, 0
    localparam logic [31:0] nop_instr = 32'h0000_0013;

endpackage

// ==== hdl/rv_bus_pkg.sv ====
package rv_bus_pkg;

    // Data and address width of both buses
    localparam int xlen = 32;

    // First fetch address after reset
    localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

    // Byte distance between consecutive instructions
    localparam logic [xlen-1:0] pc_step = 32'd4;

endpackage

// ==== hdl/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile import rv_bus_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            we,
    input  logic [4:0]      waddr,
    input  logic [xlen-1:0] wdata,
    input  logic [4:0]      raddr1,
    input  logic [4:0]      raddr2,
    output logic [xlen-1:0] rdata1,
    output logic [xlen-1:0] rdata2
);

    // x0 has no storage
    logic [xlen-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin
            regs[waddr] <= wdata;
        end
    end

    // Write-through so decode sees the value retiring this cycle
    assign rdata1 = (raddr1 == 5'd0) ? '0 :
                    (we && waddr == raddr1) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 :
                    (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

// ==== hdl/rv_fetch.sv ====
`timescale 1ns/100ps

module rv_fetch import rv_bus_pkg::*, rv_isa_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = rv_bus_pkg::reset_pc
) (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            stall,
    input  logic            flush,
    input  logic            interlock,
    input  logic [xlen-1:0] branch_target,
    input  logic [31:0]     idt,
    output logic [xlen-1:0] iad,
    output logic [xlen-1:0] pc_id,
    output logic [31:0]     instr_id
);

    logic [xlen-1:0] pc;

    assign iad = pc;

    // Flush wins over stall, the stalled instruction is being discarded anyway
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= reset_pc;
        end else if (!interlock) begin
            if (flush) begin
                pc <= branch_target;
            end else if (!stall) begin
                pc <= pc + pc_step;
            end
        end
    end

    // IF/ID
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            instr_id <= nop_instr;
        end else if (!interlock) begin
            if (flush) begin
                instr_id <= nop_instr;
            end else if (!stall) begin
                instr_id <= idt;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock && !stall) begin
            pc_id <= pc;
        end
    end

endmodule

// ==== hdl/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode import rv_bus_pkg::*, rv_isa_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            stall,
    input  logic            flush,
    input  logic            interlock,
    input  logic [xlen-1:0] pc_id,
    input  logic [31:0]     instr_id,
    input  fwd_sel_t        fwd_a,
    input  fwd_sel_t        fwd_b,
    input  logic [xlen-1:0] ex_result,
    input  logic [xlen-1:0] mem_result,
    input  logic            wb_we,
    input  logic [4:0]      wb_addr,
    input  logic [xlen-1:0] wb_data,
    output logic [4:0]      rs1,
    output logic [4:0]      rs2,
    output logic            uses_rs2,
    output logic [xlen-1:0] pc_ex,
    output logic [xlen-1:0] a_ex,
    output logic [xlen-1:0] b_ex,
    output logic [xlen-1:0] imm_ex,
    output logic [4:0]      rs2_ex,
    output logic [4:0]      rd_ex,
    output alu_op_t         alu_op_ex,
    output logic            use_imm_ex,
    output logic            is_load_ex,
    output logic            is_store_ex,
    output logic            is_branch_ex,
    output logic            bne_ex,
    output logic            reg_we_ex
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [4:0]      rd;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rdata1;
    logic [xlen-1:0] rdata2;
    alu_op_t         alu_op;
    logic            use_imm;
    logic            is_load;
    logic            is_store;
    logic            is_branch;
    logic            reg_we;
    logic            bubble;

    assign opcode = instr_id[6:0];
    assign rd     = instr_id[11:7];
    assign funct3 = instr_id[14:12];
    assign rs1    = instr_id[19:15];
    assign rs2    = instr_id[24:20];
    assign bubble = stall || flush;

    function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic sub);
        case (f3)
            f3_add:  return sub ? alu_sub : alu_add;
            f3_slt:  return alu_slt;
            f3_xor:  return alu_xor;
            f3_or:   return alu_or;
            f3_and:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    function automatic logic [xlen-1:0] fwd_mux(
        input fwd_sel_t        sel,
        input logic [xlen-1:0] rf,
        input logic [xlen-1:0] ex,
        input logic [xlen-1:0] mem
    );
        case (sel)
            fwd_ex:  return ex;
            fwd_mem: return mem;
            default: return rf;
        endcase
    endfunction

    rv_regfile rv_regfile_i (
        .clk    (clk),
        .arst_n (arst_n),
        .we     (wb_we),
        .waddr  (wb_addr),
        .wdata  (wb_data),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    // Stores leave uses_rs2 low, their data is forwarded late in execute
    always_comb begin
        imm       = {{20{instr_id[31]}}, instr_id[31:20]};
        alu_op    = alu_add;
        use_imm   = 1'b0;
        uses_rs2  = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        is_branch = 1'b0;
        reg_we    = 1'b0;
        case (opcode)
            op_reg: begin
                alu_op   = alu_from_f3(funct3, instr_id[31:25] == f7_sub);
                uses_rs2 = 1'b1;
                reg_we   = 1'b1;
            end
            op_imm: begin
                alu_op  = alu_from_f3(funct3, 1'b0);
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            op_lui: begin
                imm     = {instr_id[31:12], 12'b0};
                alu_op  = alu_pass_b;
                use_imm = 1'b1;
                reg_we  = 1'b1;
            end
            op_load: begin
                use_imm = 1'b1;
                is_load = 1'b1;
                reg_we  = 1'b1;
            end
            op_store: begin
                imm      = {{20{instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            op_branch: begin
                imm       = {{19{instr_id[31]}}, instr_id[31], instr_id[7],
                             instr_id[30:25], instr_id[11:8], 1'b0};
                uses_rs2  = 1'b1;
                is_branch = 1'b1;
            end
            default: ;
        endcase
    end

    // ID/EX control, a bubble only has to kill the side effects
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ex        <= 5'd0;
            alu_op_ex    <= alu_add;
            use_imm_ex   <= 1'b0;
            bne_ex       <= 1'b0;
            is_load_ex   <= 1'b0;
            is_store_ex  <= 1'b0;
            is_branch_ex <= 1'b0;
            reg_we_ex    <= 1'b0;
        end else if (!interlock) begin
            rd_ex        <= rd;
            alu_op_ex    <= alu_op;
            use_imm_ex   <= use_imm;
            bne_ex       <= funct3 == f3_bne;
            is_load_ex   <= is_load && !bubble;
            is_store_ex  <= is_store && !bubble;
            is_branch_ex <= is_branch && !bubble;
            reg_we_ex    <= reg_we && !bubble;
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock) begin
            pc_ex  <= pc_id;
            a_ex   <= fwd_mux(fwd_a, rdata1, ex_result, mem_result);
            b_ex   <= fwd_mux(fwd_b, rdata2, ex_result, mem_result);
            imm_ex <= imm;
            rs2_ex <= rs2;
        end
    end

endmodule

// ==== hdl/rv_execute.sv ====
`timescale 1ns/100ps

module rv_execute import rv_bus_pkg::*, rv_isa_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            interlock,
    input  logic [xlen-1:0] pc_ex,
    input  logic [xlen-1:0] a_ex,
    input  logic [xlen-1:0] b_ex,
    input  logic [xlen-1:0] imm_ex,
    input  logic [4:0]      rd_ex,
    input  alu_op_t         alu_op_ex,
    input  logic            use_imm_ex,
    input  logic            is_load_ex,
    input  logic            is_store_ex,
    input  logic            is_branch_ex,
    input  logic            bne_ex,
    input  logic            reg_we_ex,
    input  logic            fwd_store,
    input  logic [xlen-1:0] mem_result,
    output logic [xlen-1:0] ex_result,
    output logic            branch_taken,
    output logic [xlen-1:0] branch_target,
    output logic [xlen-1:0] addr_mem,
    output logic [xlen-1:0] store_data_mem,
    output logic [4:0]      rd_mem,
    output logic            is_load_mem,
    output logic            is_store_mem,
    output logic            reg_we_mem
);

    logic [xlen-1:0] opb;
    logic            equal;

    assign opb = use_imm_ex ? imm_ex : b_ex;

    always_comb begin
        case (alu_op_ex)
            alu_add:    ex_result = a_ex + opb;
            alu_sub:    ex_result = a_ex - opb;
            alu_and:    ex_result = a_ex & opb;
            alu_or:     ex_result = a_ex | opb;
            alu_xor:    ex_result = a_ex ^ opb;
            alu_slt:    ex_result = {{(xlen-1){1'b0}}, $signed(a_ex) < $signed(opb)};
            alu_pass_b: ex_result = opb;
            default:    ex_result = a_ex + opb;
        endcase
    end

    // Branches compare the two registers, never the immediate
    assign equal         = a_ex == b_ex;
    assign branch_taken  = is_branch_ex && (bne_ex ? !equal : equal);
    assign branch_target = pc_ex + imm_ex;

    // EX/MEM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_mem       <= 5'd0;
            is_load_mem  <= 1'b0;
            is_store_mem <= 1'b0;
            reg_we_mem   <= 1'b0;
        end else if (!interlock) begin
            rd_mem       <= rd_ex;
            is_load_mem  <= is_load_ex;
            is_store_mem <= is_store_ex;
            reg_we_mem   <= reg_we_ex;
        end
    end

    // Load right before a store of the same register
    always_ff @(posedge clk) begin
        if (!interlock) begin
            addr_mem       <= ex_result;
            store_data_mem <= fwd_store ? mem_result : b_ex;
        end
    end

endmodule

// ==== hdl/rv_memory.sv ====
`timescale 1ns/100ps

module rv_memory import rv_bus_pkg::*; (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            interlock,
    input  logic [xlen-1:0] addr_mem,
    input  logic [xlen-1:0] store_data_mem,
    input  logic [4:0]      rd_mem,
    input  logic            is_load_mem,
    input  logic            is_store_mem,
    input  logic            reg_we_mem,
    input  logic [xlen-1:0] drdata,
    input  logic            ackd_n,
    output logic [xlen-1:0] dad,
    output logic [xlen-1:0] dwdata,
    output logic            mreq,
    output logic            write,
    output logic [xlen-1:0] mem_result,
    output logic            wb_we,
    output logic [4:0]      wb_addr,
    output logic [xlen-1:0] wb_data
);

    logic            done;
    logic [xlen-1:0] load_q;

    assign dad    = addr_mem;
    assign dwdata = store_data_mem;
    assign mreq   = (is_load_mem || is_store_mem) && !done;
    assign write  = is_store_mem && !done;

    // Access finished while the fetch side still holds the pipeline.
    // Drop the request so it is not repeated, and keep the load data.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (!interlock) begin
            done <= 1'b0;
        end else if (mreq && !ackd_n) begin
            done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mreq && !ackd_n) begin
            load_q <= drdata;
        end
    end

    assign mem_result = !is_load_mem ? addr_mem :
                        done         ? load_q   : drdata;

    // MEM/WB
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_we   <= 1'b0;
            wb_addr <= 5'd0;
        end else if (!interlock) begin
            wb_we   <= reg_we_mem;
            wb_addr <= rd_mem;
        end
    end

    always_ff @(posedge clk) begin
        if (!interlock) begin
            wb_data <= mem_result;
        end
    end

endmodule

// ==== hdl/rv_hazard.sv ====
`timescale 1ns/100ps

module rv_hazard import rv_isa_pkg::*; (
    input  logic     [4:0] rs1,
    input  logic     [4:0] rs2,
    input  logic           uses_rs2,
    input  logic     [4:0] rd_ex,
    input  logic           reg_we_ex,
    input  logic           is_load_ex,
    input  logic     [4:0] rs2_ex,
    input  logic     [4:0] rd_mem,
    input  logic           reg_we_mem,
    input  logic           is_load_mem,
    input  logic           branch_taken,
    input  logic           acki_n,
    input  logic           ackd_n,
    input  logic           mreq,
    output fwd_sel_t       fwd_a,
    output fwd_sel_t       fwd_b,
    output logic           fwd_store,
    output logic           stall,
    output logic           flush,
    output logic           interlock
);

    logic ex_wr;
    logic mem_wr;

    // x0 is never a producer
    assign ex_wr  = reg_we_ex && rd_ex != 5'd0;
    assign mem_wr = reg_we_mem && rd_mem != 5'd0;

    // Execute is younger than memory, so it is checked first
    assign fwd_a = (ex_wr && rd_ex == rs1)   ? fwd_ex  :
                   (mem_wr && rd_mem == rs1) ? fwd_mem : fwd_none;
    assign fwd_b = (ex_wr && rd_ex == rs2)   ? fwd_ex  :
                   (mem_wr && rd_mem == rs2) ? fwd_mem : fwd_none;

    assign fwd_store = mem_wr && is_load_mem && rd_mem == rs2_ex;

    // Load data is not there yet, hold decode one cycle
    assign stall = is_load_ex && ex_wr && (rd_ex == rs1 || (uses_rs2 && rd_ex == rs2));

    assign flush = branch_taken;

    assign interlock = acki_n || (mreq && ackd_n);

endmodule

// ==== hdl/rv_core.sv ====
`timescale 1ns/100ps

module rv_core import rv_bus_pkg::*, rv_isa_pkg::*; #(
    parameter logic [xlen-1:0] reset_pc = rv_bus_pkg::reset_pc
) (
    input  logic            clk,
    input  logic            arst_n,

    // Instruction bus
    output logic [xlen-1:0] iad,
    input  logic [31:0]     idt,
    input  logic            acki_n,

    // Data bus
    output logic [xlen-1:0] dad,
    output logic [xlen-1:0] dwdata,
    output logic            mreq,
    output logic            write,
    input  logic [xlen-1:0] drdata,
    input  logic            ackd_n
);

    // Hazard control
    logic            stall;
    logic            flush;
    logic            interlock;
    fwd_sel_t        fwd_a;
    fwd_sel_t        fwd_b;
    logic            fwd_store;

    // IF/ID
    logic [xlen-1:0] pc_id;
    logic [31:0]     instr_id;

    // Decode
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic            uses_rs2;

    // ID/EX
    logic [xlen-1:0] pc_ex;
    logic [xlen-1:0] a_ex;
    logic [xlen-1:0] b_ex;
    logic [xlen-1:0] imm_ex;
    logic [4:0]      rs2_ex;
    logic [4:0]      rd_ex;
    alu_op_t         alu_op_ex;
    logic            use_imm_ex;
    logic            is_load_ex;
    logic            is_store_ex;
    logic            is_branch_ex;
    logic            bne_ex;
    logic            reg_we_ex;

    // Execute
    logic [xlen-1:0] ex_result;
    logic            branch_taken;
    logic [xlen-1:0] branch_target;

    // EX/MEM
    logic [xlen-1:0] addr_mem;
    logic [xlen-1:0] store_data_mem;
    logic [4:0]      rd_mem;
    logic            is_load_mem;
    logic            is_store_mem;
    logic            reg_we_mem;

    // Memory and MEM/WB
    logic [xlen-1:0] mem_result;
    logic            wb_we;
    logic [4:0]      wb_addr;
    logic [xlen-1:0] wb_data;

    rv_fetch #(
        .reset_pc (reset_pc)
    ) rv_fetch_i (.*);

    rv_decode rv_decode_i (.*);

    rv_execute rv_execute_i (.*);

    rv_memory rv_memory_i (.*);

    rv_hazard rv_hazard_i (.*);

endmodule

// ==== dv/rv_core_checker.sv ====
`timescale 1ns/100ps

module rv_core_checker (
    input logic        clk,
    input logic        arst_n,
    input logic [31:0] iad,
    input logic        acki_n,
    input logic [31:0] dad,
    input logic [31:0] dwdata,
    input logic        mreq,
    input logic        write,
    input logic        ackd_n
);

    int unsigned fail_count = 0;

    write_has_req: assert property (@(posedge clk) disable iff (!arst_n)
        write |-> mreq)
    else begin
        $error("write high without mreq");
        fail_count++;
    end

    // Request held until the data side acknowledges
    data_stable: assert property (@(posedge clk) disable iff (!arst_n)
        mreq && ackd_n |=> mreq && $stable(dad) && $stable(dwdata) && $stable(write))
    else begin
        $error("data bus changed before ackd_n");
        fail_count++;
    end

    fetch_stable: assert property (@(posedge clk) disable iff (!arst_n)
        acki_n |=> $stable(iad))
    else begin
        $error("iad changed before acki_n");
        fail_count++;
    end

    fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        iad[1:0] == 2'b00)
    else begin
        $error("iad not word aligned");
        fail_count++;
    end

    idle_in_reset: assert property (@(posedge clk) !arst_n |-> !mreq)
    else begin
        $error("mreq high during reset");
        fail_count++;
    end

endmodule

bind rv_core rv_core_checker rv_core_checker_i (.*);

// ==== dv/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb;

    localparam logic [31:0] nop_word   = 32'h0000_0013;
    localparam logic [31:0] halt_instr = 32'h0000_0063;
    localparam int          store_timeout = 3000;
    localparam int          drain_cycles  = 20;

    logic        clk;
    logic        arst_n;
    logic [31:0] iad;
    logic [31:0] idt;
    logic        acki_n;
    logic [31:0] dad;
    logic [31:0] dwdata;
    logic        mreq;
    logic        write;
    logic [31:0] drdata;
    logic        ackd_n;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] lfsr_state;
    logic        bp_on;
    int          prog_len;
    int          errors;
    int          tests;
    int          stores_seen;
    int          stores_total;

    rv_core rv_core_i (
        .clk    (clk),
        .arst_n (arst_n),
        .iad    (iad),
        .idt    (idt),
        .acki_n (acki_n),
        .dad    (dad),
        .dwdata (dwdata),
        .mreq   (mreq),
        .write  (write),
        .drdata (drdata),
        .ackd_n (ackd_n)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bit(output logic b);
        b = lfsr_state[0];
        lfsr_state = lfsr_step(lfsr_state);
    endtask

    // Mixes the whole byte address into the word
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], ~addr[15:0]};
    endfunction

    function automatic int total_errors();
        return errors + rv_core_i.rv_core_checker_i.fail_count;
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic sub,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [4:0] rs2);
        return {sub ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input int imm);
        return {imm[11:0], rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [4:0] rs1,
                                           input int imm);
        return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                           input int imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_br(input logic [2:0] f3, input logic [4:0] rs1,
                                           input logic [4:0] rs2, input int off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    task automatic emit(input logic [31:0] ins);
        imem[prog_len] = ins;
        prog_len++;
    endtask

    task automatic load_program(input int prog);
        for (int i = 0; i < 64; i++) begin
            imem[i] = nop_word;
        end
        prog_len = 0;
        case (prog)
            // Dependent ALU chain
            0: begin
                emit(enc_i(3'd0, 1, 0, 5));
                emit(enc_i(3'd0, 2, 1, 7));
                emit(enc_r(3'd0, 1'b0, 3, 1, 2));
                emit(enc_r(3'd0, 1'b1, 4, 3, 1));
                emit(enc_sw(3, 0, 28));
                emit(enc_r(3'd4, 1'b0, 5, 4, 2));
                emit(enc_lui(6, 20'h12345));
                emit(enc_r(3'd6, 1'b0, 7, 6, 5));
                emit(enc_r(3'd0, 1'b1, 8, 3, 7));
                emit(enc_r(3'd2, 1'b0, 9, 8, 4));
                emit(enc_i(3'd2, 10, 4, -1));
                emit(enc_i(3'd4, 11, 7, 2047));
                emit(enc_i(3'd6, 12, 11, -256));
                emit(enc_i(3'd7, 13, 12, 240));
                emit(enc_sw(13, 0, 0));
                emit(enc_sw(12, 0, 4));
                emit(enc_sw(11, 0, 8));
                emit(enc_sw(10, 0, 12));
                emit(enc_sw(9, 0, 16));
                emit(enc_sw(8, 0, 20));
                emit(enc_sw(7, 0, 24));
                emit(enc_sw(4, 0, 32));
                emit(halt_instr);
            end
            // Loads used at once, loads stored at once
            1: begin
                emit(enc_i(3'd0, 1, 0, 32));
                emit(enc_lw(2, 1, 0));
                emit(enc_r(3'd0, 1'b0, 3, 2, 2));
                emit(enc_sw(3, 1, 0));
                emit(enc_lw(4, 1, 4));
                emit(enc_sw(4, 1, 8));
                emit(enc_lw(5, 1, 0));
                emit(enc_i(3'd0, 6, 5, 1));
                emit(enc_sw(6, 1, 12));
                emit(enc_lw(7, 1, 12));
                emit(enc_lw(8, 1, 8));
                emit(enc_r(3'd0, 1'b0, 9, 7, 8));
                emit(enc_sw(9, 1, 16));
                emit(enc_i(3'd0, 11, 0, 40));
                emit(enc_sw(11, 1, 24));
                emit(enc_lw(12, 1, 24));
                emit(enc_sw(9, 12, 0));
                emit(enc_lw(13, 1, 16));
                emit(enc_sw(13, 1, 4));
                emit(halt_instr);
            end
            // Taken and untaken BEQ and BNE, stores in every shadow
            2: begin
                emit(enc_i(3'd0, 1, 0, 3));
                emit(enc_i(3'd0, 2, 0, 3));
                emit(enc_br(3'd0, 1, 2, 12));
                emit(enc_sw(1, 0, 0));
                emit(enc_sw(2, 0, 4));
                emit(enc_br(3'd1, 1, 2, 8));
                emit(enc_sw(1, 0, 8));
                emit(enc_i(3'd0, 3, 0, 0));
                emit(enc_i(3'd0, 3, 3, 1));
                emit(enc_sw(3, 0, 12));
                emit(enc_br(3'd1, 3, 1, -8));
                emit(enc_sw(3, 0, 16));
                emit(enc_br(3'd0, 1, 0, 8));
                emit(enc_sw(1, 0, 20));
                emit(enc_br(3'd1, 1, 0, 12));
                emit(enc_sw(0, 0, 24));
                emit(enc_sw(0, 0, 28));
                emit(enc_sw(2, 0, 32));
                emit(halt_instr);
            end
            default: ;
        endcase
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return sub ? a - b : a + b;
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd6:    return a | b;
            3'd7:    return a & b;
            default: return 32'd0;
        endcase
    endfunction

    // Sequential ISA model, one instruction at a time
    task automatic golden_run();
        logic [31:0] regs [0:31];
        logic [31:0] gmem [0:63];
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] addr;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_b;
        logic        wr;
        exp_addr.delete();
        exp_data.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        for (int i = 0; i < 64; i++) begin
            gmem[i] = fill_word(i * 4);
        end
        pc = 32'd0;
        for (int steps = 0; steps < 1000; steps++) begin
            ins = imem[pc[7:2]];
            if (ins == halt_instr) begin
                break;
            end
            a       = regs[ins[19:15]];
            b       = regs[ins[24:20]];
            imm_i   = {{20{ins[31]}}, ins[31:20]};
            imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b   = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            next_pc = pc + 32'd4;
            wr      = 1'b1;
            res     = 32'd0;
            case (ins[6:0])
                7'b0110011: res = alu_ref(ins[14:12], ins[30], a, b);
                7'b0010011: res = alu_ref(ins[14:12], 1'b0, a, imm_i);
                7'b0110111: res = {ins[31:12], 12'h000};
                7'b0000011: begin
                    addr = a + imm_i;
                    res  = gmem[addr[7:2]];
                end
                7'b0100011: begin
                    wr   = 1'b0;
                    addr = a + imm_s;
                    gmem[addr[7:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                7'b1100011: begin
                    wr = 1'b0;
                    if ((a == b) ^ ins[12]) begin
                        next_pc = pc + imm_b;
                    end
                end
                default: wr = 1'b0;
            endcase
            if (wr && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
            end
            pc = next_pc;
        end
    endtask

    task automatic check_idle();
        assert (mreq === 1'b0) else begin
            $display("mismatch at %0t: mreq expected 0, got %b", $time, mreq);
            errors++;
        end
        assert (write === 1'b0) else begin
            $display("mismatch at %0t: write expected 0, got %b", $time, write);
            errors++;
        end
        assert (iad === 32'd0) else begin
            $display("mismatch at %0t: iad expected 00000000, got %h", $time, iad);
            errors++;
        end
    endtask

    task automatic check_store(input logic [31:0] a, input logic [31:0] d);
        assert (exp_addr.size() > 0) else begin
            $display("store to %h at %0t arrived with no store left to expect", a, $time);
            errors++;
        end
        if (exp_addr.size() > 0) begin
            assert (a === exp_addr[0]) else begin
                $display("mismatch at %0t: dad expected %h, got %h", $time, exp_addr[0], a);
                errors++;
            end
            assert (d === exp_data[0]) else begin
                $display("mismatch at %0t: dwdata expected %h, got %h",
                         $time, exp_data[0], d);
                errors++;
            end
            void'(exp_addr.pop_front());
            void'(exp_data.pop_front());
        end
        dmem[a[7:2]] = d;
        stores_seen++;
    endtask

    // Memory responses and back-pressure
    always @(negedge clk) begin : drive_memories
        logic b0;
        logic b1;
        idt    = imem[iad[7:2]];
        drdata = dmem[dad[7:2]];
        if (bp_on) begin
            take_bit(b0);
            take_bit(b1);
            acki_n = b0 & b1;
            take_bit(b0);
            take_bit(b1);
            ackd_n = b0 & b1;
        end else begin
            acki_n = 1'b0;
            ackd_n = 1'b0;
        end
    end

    // Values here are the ones present at the completing edge
    always @(posedge clk) begin
        if (arst_n && mreq && !ackd_n && write) begin
            check_store(dad, dwdata);
        end
    end

    task automatic run_test(input string name, input int prog, input logic bp);
        int err0;
        int cyc;
        @(negedge clk);
        arst_n = 1'b0;
        err0   = total_errors();
        bp_on  = bp;
        load_program(prog);
        for (int i = 0; i < 64; i++) begin
            dmem[i] = fill_word(i * 4);
        end
        golden_run();
        stores_seen = 0;
        repeat (5) begin
            @(negedge clk);
            check_idle();
        end
        arst_n = 1'b1;
        check_idle();
        cyc = 0;
        while (exp_addr.size() > 0 && cyc < store_timeout) begin
            @(negedge clk);
            cyc++;
        end
        if (exp_addr.size() > 0) begin
            $display("timeout in test %s, %0d stores never arrived", name, exp_addr.size());
            errors++;
        end
        // Late stores from a flushed shadow would show up here
        repeat (drain_cycles) @(negedge clk);
        tests++;
        stores_total += stores_seen;
        $display("test %-14s %0d stores, %0d errors", name, stores_seen,
                 total_errors() - err0);
    endtask

    initial begin
        clk          = 1'b0;
        arst_n       = 1'b0;
        idt          = nop_word;
        acki_n       = 1'b0;
        ackd_n       = 1'b1;
        drdata       = 32'd0;
        bp_on        = 1'b0;
        lfsr_state   = 32'h971d;
        errors       = 0;
        tests        = 0;
        stores_seen  = 0;
        stores_total = 0;
        prog_len     = 0;
        for (int i = 0; i < 64; i++) begin
            imem[i] = nop_word;
            dmem[i] = 32'd0;
        end
        run_test("reset", 3, 1'b0);
        run_test("alu_chain", 0, 1'b0);
        run_test("load_use", 1, 1'b0);
        run_test("branches", 2, 1'b0);
        run_test("alu_chain_bp", 0, 1'b1);
        run_test("load_use_bp", 1, 1'b1);
        run_test("branches_bp", 2, 1'b1);
        $display("tests %0d, stores %0d, errors %0d", tests, stores_total, total_errors());
        if (total_errors() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== rv_core.f ====
hdl/rv_isa_pkg.sv
hdl/rv_bus_pkg.sv
hdl/rv_regfile.sv
hdl/rv_fetch.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_memory.sv
hdl/rv_hazard.sv
hdl/rv_core.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - hdl/rv_isa_pkg.sv
  - hdl/rv_bus_pkg.sv
  - hdl/rv_regfile.sv
  - hdl/rv_fetch.sv
  - hdl/rv_decode.sv
  - hdl/rv_execute.sv
  - hdl/rv_memory.sv
  - hdl/rv_hazard.sv
  - hdl/rv_core.sv
  - target: simulation
    files:
      - dv/rv_core_checker.sv
      - dv/rv_core_tb.sv
